//--- design/alu_ops_pkg.sv
// Shared widths, packet and configuration structs, opcode and state enums for the ALU engine
package alu_ops_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int DATA_WIDTH       = 32;
    localparam int ADDR_WIDTH       = 16;
    localparam int ROUTE_WIDTH      = 4;
    localparam int DESC_COUNT_WIDTH = 16;

    // --------------------------------------------------
    // Opcodes and states
    // --------------------------------------------------
    // All operations wrap at DATA_WIDTH, MAX is unsigned
    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_MUL  = 3'd3,
        ALU_AND  = 3'd4,
        ALU_OR   = 3'd5,
        ALU_XOR  = 3'd6,
        ALU_MAX  = 3'd7
    } alu_opcode_e;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        SETUP_REQUEST,
        SETUP_WAIT,
        RUN,
        PAUSE_TRANS,
        PAUSE,
        DONE
    } engine_state_e;

    // --------------------------------------------------
    // Packets and job control
    // --------------------------------------------------
    typedef struct packed {
        logic [ROUTE_WIDTH-1:0] route_from;
        logic [ROUTE_WIDTH-1:0] route_to;
        logic [ADDR_WIDTH-1:0]  address;
    } packet_meta_t;

    typedef struct packed {
        packet_meta_t          meta;
        logic [DATA_WIDTH-1:0] data;
    } packet_t;

    // Opcode, operand and the route stamped onto every result
    typedef struct packed {
        alu_opcode_e            opcode;
        logic [DATA_WIDTH-1:0]  operand;
        logic [ROUTE_WIDTH-1:0] route_from;
        logic [ROUTE_WIDTH-1:0] route_to;
    } alu_config_t;

    typedef struct packed {
        logic [DESC_COUNT_WIDTH-1:0] packet_count;
    } descriptor_t;

endpackage : alu_ops_pkg

//--- design/packet_fifo.sv
// Synchronous FWFT packet FIFO with full, empty and programmable-full flags for engine buffering
module packet_fifo import alu_ops_pkg::*; #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic    ap_clk,
    input  logic    areset_generator,
    input  logic    push,
    input  packet_t push_packet,
    input  logic    pop,
    output packet_t pop_packet,
    output logic    full,
    output logic    empty,
    output logic    prog_full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    packet_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Requests against a full or empty buffer are dropped
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

    // Head entry always visible
    assign pop_packet = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_packet;
        end
    end

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge ap_clk) disable iff (areset_generator)
        push |-> !full);
    a_no_pop_empty: assert property (@(posedge ap_clk) disable iff (areset_generator)
        pop |-> !empty);

endmodule : packet_fifo

//--- design/alu_ops_control.sv
// Job FSM that takes descriptor and configuration, requests setup and gates input FIFO pops
module alu_ops_control import alu_ops_pkg::*; #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  logic                   descriptor_valid,
    input  descriptor_t            descriptor,
    input  logic                   config_valid,
    input  alu_config_t            config_in,
    input  logic                   in_empty,
    input  logic                   out_prog_full,
    input  logic                   last_pushed,
    output logic                   config_request,
    output alu_config_t            active_config,
    output logic [COUNT_WIDTH-1:0] packet_count,
    output logic                   pop,
    output logic                   job_start
);

    engine_state_e state;
    engine_state_e next_state;

    // --------------------------------------------------
    // State register and transitions
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (descriptor_valid) begin
                    next_state = SETUP_REQUEST;
                end
            end
            SETUP_REQUEST: begin
                next_state = SETUP_WAIT;
            end
            SETUP_WAIT: begin
                if (config_valid) begin
                    next_state = RUN;
                end
            end
            RUN: begin
                if (last_pushed) begin
                    next_state = DONE;
                end else if (out_prog_full) begin
                    next_state = PAUSE_TRANS;
                end
            end
            // In-flight results may still finish the job while paused
            PAUSE_TRANS: begin
                next_state = last_pushed ? DONE : PAUSE;
            end
            PAUSE: begin
                if (last_pushed) begin
                    next_state = DONE;
                end else if (!out_prog_full) begin
                    next_state = RUN;
                end
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // --------------------------------------------------
    // Pulses and latched job parameters
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_request <= 1'b0;
            job_start      <= 1'b0;
        end else begin
            config_request <= (state == SETUP_REQUEST);
            job_start      <= (state == SETUP_WAIT) && config_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (state == IDLE && descriptor_valid) begin
            packet_count <= COUNT_WIDTH'(descriptor.packet_count);
        end
        if (state == SETUP_WAIT && config_valid) begin
            active_config <= config_in;
        end
    end

    // Pop only while running and the output side has room
    assign pop = (state == RUN) && !in_empty && !out_prog_full;

    a_config_in_setup_wait: assert property (@(posedge ap_clk) disable iff (areset_generator)
        config_valid |-> state == SETUP_WAIT);

endmodule : alu_ops_control

//--- design/alu_ops_kernel.sv
// Registered ALU stage that applies the configured opcode and operand to popped packet data
module alu_ops_kernel import alu_ops_pkg::*; (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  alu_opcode_e           opcode,
    input  logic [DATA_WIDTH-1:0] operand,
    input  logic                  data_valid,
    input  packet_t               data_packet,
    output logic                  result_valid,
    output packet_meta_t          result_meta,
    output logic [DATA_WIDTH-1:0] result_data
);

    logic [DATA_WIDTH-1:0] data;
    logic [DATA_WIDTH-1:0] alu_out;

    assign data = data_packet.data;

    always_comb begin
        case (opcode)
            ALU_PASS: alu_out = data;
            ALU_ADD:  alu_out = data + operand;
            ALU_SUB:  alu_out = data - operand;
            // Low half of the product
            ALU_MUL:  alu_out = data * operand;
            ALU_AND:  alu_out = data & operand;
            ALU_OR:   alu_out = data | operand;
            ALU_XOR:  alu_out = data ^ operand;
            ALU_MAX:  alu_out = (data > operand) ? data : operand;
            default:  alu_out = data;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= data_valid;
        end
    end

    // Meta rides alongside for the builder
    always_ff @(posedge ap_clk) begin
        result_data <= alu_out;
        result_meta <= data_packet.meta;
    end

    a_opcode_known: assert property (@(posedge ap_clk) disable iff (areset_generator)
        data_valid |-> !$isunknown(opcode));

endmodule : alu_ops_kernel

//--- design/packet_builder.sv
// Builds result packets with the configured route and counts pushes to flag job completion
module packet_builder import alu_ops_pkg::*; #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  logic                   job_start,
    input  logic [COUNT_WIDTH-1:0] packet_count,
    input  logic [ROUTE_WIDTH-1:0] route_from,
    input  logic [ROUTE_WIDTH-1:0] route_to,
    input  logic                   result_valid,
    input  packet_meta_t           result_meta,
    input  logic [DATA_WIDTH-1:0]  result_data,
    output logic                   push,
    output packet_t                push_packet,
    output logic                   last_pushed,
    output logic                   done
);

    logic [COUNT_WIDTH-1:0] push_count;

    // --------------------------------------------------
    // Result packet register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push <= 1'b0;
        end else begin
            push <= result_valid;
        end
    end

    // Route from the job, address from the source packet
    always_ff @(posedge ap_clk) begin
        push_packet.meta.route_from <= route_from;
        push_packet.meta.route_to   <= route_to;
        push_packet.meta.address    <= result_meta.address;
        push_packet.data            <= result_data;
    end

    // --------------------------------------------------
    // Completion tracking
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push_count <= '0;
        end else if (job_start) begin
            push_count <= '0;
        end else if (push) begin
            push_count <= push_count + 1'b1;
        end
    end

    assign last_pushed = push && (push_count + COUNT_WIDTH'(1) == packet_count);

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done <= 1'b0;
        end else begin
            done <= last_pushed;
        end
    end

endmodule : packet_builder

//--- design/alu_ops_engine.sv
// ALU packet engine top level that registers inputs and wires the FIFOs and pipeline stages
module alu_ops_engine import alu_ops_pkg::*; #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8,
    parameter int COUNT_WIDTH = 16
) (
    input  logic        ap_clk,
    input  logic        areset_generator,
    input  logic        descriptor_valid,
    input  descriptor_t descriptor,
    input  logic        config_valid,
    input  alu_config_t config_in,
    output logic        config_request,
    input  logic        in_valid,
    input  packet_t     in_packet,
    output logic        in_full,
    output logic        out_valid,
    output packet_t     out_packet,
    input  logic        out_ready,
    output logic        done
);

    logic                   descriptor_valid_r;
    descriptor_t            descriptor_r;
    logic                   config_valid_r;
    alu_config_t            config_r;
    logic                   in_valid_r;
    packet_t                in_packet_r;
    packet_t                in_head;
    logic                   in_empty;
    logic                   out_empty;
    logic                   out_prog_full;
    logic                   pop;
    logic                   job_start;
    logic                   last_pushed;
    alu_config_t            active_config;
    logic [COUNT_WIDTH-1:0] packet_count;
    logic                   result_valid;
    packet_meta_t           result_meta;
    logic [DATA_WIDTH-1:0]  result_data;
    logic                   push;
    packet_t                push_packet;

    // --------------------------------------------------
    // Input registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            descriptor_valid_r <= 1'b0;
            config_valid_r     <= 1'b0;
            in_valid_r         <= 1'b0;
        end else begin
            descriptor_valid_r <= descriptor_valid;
            config_valid_r     <= config_valid;
            in_valid_r         <= in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_r <= descriptor;
        config_r     <= config_in;
        in_packet_r  <= in_packet;
    end

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    // Early full, so a strobe still in the input register always fits
    packet_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .PROG_THRESH(PROG_THRESH)) in_fifo_i (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .push(in_valid_r), .push_packet(in_packet_r),
        .pop(pop), .pop_packet(in_head),
        .full(), .empty(in_empty), .prog_full(in_full)
    );

    alu_ops_control #(.COUNT_WIDTH(COUNT_WIDTH)) control_i (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .descriptor_valid(descriptor_valid_r), .descriptor(descriptor_r),
        .config_valid(config_valid_r), .config_in(config_r),
        .in_empty(in_empty), .out_prog_full(out_prog_full), .last_pushed(last_pushed),
        .config_request(config_request), .active_config(active_config),
        .packet_count(packet_count), .pop(pop), .job_start(job_start)
    );

    alu_ops_kernel kernel_i (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .opcode(active_config.opcode), .operand(active_config.operand),
        .data_valid(pop), .data_packet(in_head),
        .result_valid(result_valid), .result_meta(result_meta), .result_data(result_data)
    );

    packet_builder #(.COUNT_WIDTH(COUNT_WIDTH)) builder_i (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .job_start(job_start), .packet_count(packet_count),
        .route_from(active_config.route_from), .route_to(active_config.route_to),
        .result_valid(result_valid), .result_meta(result_meta), .result_data(result_data),
        .push(push), .push_packet(push_packet),
        .last_pushed(last_pushed), .done(done)
    );

    // Consumer drains the head with valid/ready
    packet_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .PROG_THRESH(PROG_THRESH)) out_fifo_i (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .push(push), .push_packet(push_packet),
        .pop(out_valid && out_ready), .pop_packet(out_packet),
        .full(), .empty(out_empty), .prog_full(out_prog_full)
    );

    assign out_valid = !out_empty;

endmodule : alu_ops_engine

//--- dv/alu_ops_checks.svh
// Compare tasks, xorshift generator and ALU reference model, included inside the engine testbench
`ifndef ALU_OPS_CHECKS_SVH
`define ALU_OPS_CHECKS_SVH

// --------------------------------------------------
// Reference model
// --------------------------------------------------
function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Wraps at 32 bits, SUB is data minus operand, MAX compares unsigned
function automatic logic [DATA_WIDTH-1:0] alu_model(input alu_opcode_e op,
        input logic [DATA_WIDTH-1:0] d, input logic [DATA_WIDTH-1:0] o);
    case (op)
        ALU_ADD: return d + o;
        ALU_SUB: return d - o;
        ALU_MUL: return d * o;
        ALU_AND: return d & o;
        ALU_OR:  return d | o;
        ALU_XOR: return d ^ o;
        ALU_MAX: return (d > o) ? d : o;
        default: return d;
    endcase
endfunction

// Route comes from the job, address from the source packet
function automatic packet_t expected_packet(input alu_config_t cfg, input packet_t p);
    packet_t e;
    e.meta.route_from = cfg.route_from;
    e.meta.route_to   = cfg.route_to;
    e.meta.address    = p.meta.address;
    e.data            = alu_model(cfg.opcode, p.data, cfg.operand);
    return e;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_packet(input string what, input packet_t exp, input packet_t act);
    if (act !== exp) begin
        $display("Error in %s: %s expected %h/%h/%h/%h, actual %h/%h/%h/%h", test_name, what,
            exp.meta.route_from, exp.meta.route_to, exp.meta.address, exp.data,
            act.meta.route_from, act.meta.route_to, act.meta.address, act.data);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        $display("Error in %s: %s expected %b, actual %b", test_name, what, exp, act);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
        $display("Error in %s: %s expected %0d, actual %0d", test_name, what, exp, act);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

`endif

//--- dv/alu_ops_engine_tb.sv
// Directed testbench for the ALU packet engine; runs jobs through the DUT and reports a verdict
module alu_ops_engine_tb import alu_ops_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED           = 32'h190b3b20;
    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          EV_REQUEST     = 0;
    localparam int          EV_PACKET      = 1;
    localparam int          EV_DONE        = 2;

    logic        ap_clk;
    logic        areset_generator;
    logic        descriptor_valid;
    descriptor_t descriptor;
    logic        config_valid;
    alu_config_t config_in;
    logic        config_request;
    logic        in_valid;
    packet_t     in_packet;
    logic        in_full;
    logic        out_valid;
    packet_t     out_packet;
    logic        out_ready;
    logic        done;

    logic [31:0] rng_state = SEED;
    string       test_name = "none";
    int          pass_count = 0;
    int          fail_count = 0;
    int          test_start_fails = 0;
    bit          aborted = 1'b0;
    packet_t     received[$];
    int          done_count = 0;
    int          request_count = 0;

    `include "alu_ops_checks.svh"

    alu_ops_engine dut_i (.*);

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // Outputs are sampled on the falling edge, a transfer completes on the next rising edge
    always @(negedge ap_clk) begin
        if (!areset_generator) begin
            if (out_valid && out_ready) begin
                received.push_back(out_packet);
            end
            if (done) begin
                done_count++;
            end
            if (config_request) begin
                request_count++;
            end
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic alu_config_t random_config(input alu_opcode_e op);
        alu_config_t cfg;
        logic [31:0] r;
        r = next_random();
        cfg.opcode     = op;
        cfg.operand    = next_random();
        cfg.route_from = r[3:0];
        cfg.route_to   = r[7:4];
        return cfg;
    endfunction

    task automatic make_packets(input int n, output packet_t pkts[$]);
        packet_t     p;
        logic [31:0] r;
        pkts.delete();
        repeat (n) begin
            r = next_random();
            p.meta.route_from = r[3:0];
            p.meta.route_to   = r[7:4];
            p.meta.address    = r[31:16];
            p.data            = next_random();
            pkts.push_back(p);
        end
    endtask

    task automatic begin_test(input string name);
        test_name        = name;
        test_start_fails = fail_count;
    endtask

    task automatic end_test();
        $display("Test %s finished, %0d mismatches", test_name, fail_count - test_start_fails);
    endtask

    function automatic int event_count(input int kind);
        case (kind)
            EV_REQUEST: return request_count;
            EV_PACKET:  return received.size();
            default:    return done_count;
        endcase
    endfunction

    task automatic wait_for_count(input int kind, input int target, input string what);
        int n;
        n = 0;
        if (aborted) begin
            return;
        end
        while (event_count(kind) < target && n < TIMEOUT_CYCLES) begin
            @(negedge ap_clk);
            n++;
        end
        if (event_count(kind) < target) begin
            $display("Timeout in %s: %s", test_name, what);
            fail_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic drive_descriptor(input int count);
        @(posedge ap_clk);
        descriptor_valid        <= 1'b1;
        descriptor.packet_count <= DESC_COUNT_WIDTH'(count);
        @(posedge ap_clk);
        descriptor_valid <= 1'b0;
    endtask

    task automatic drive_config(input alu_config_t cfg);
        @(posedge ap_clk);
        config_valid <= 1'b1;
        config_in    <= cfg;
        @(posedge ap_clk);
        config_valid <= 1'b0;
    endtask

    task automatic send_packets(input packet_t pkts[$]);
        int n;
        foreach (pkts[i]) begin
            n = 0;
            @(negedge ap_clk);
            // Hold off while the input FIFO sits above its threshold
            while (in_full && n < TIMEOUT_CYCLES) begin
                @(posedge ap_clk);
                in_valid <= 1'b0;
                @(negedge ap_clk);
                n++;
            end
            if (in_full) begin
                $display("Timeout in %s: in_full never dropped", test_name);
                fail_count++;
                aborted = 1'b1;
                return;
            end
            @(posedge ap_clk);
            in_valid  <= 1'b1;
            in_packet <= pkts[i];
        end
        @(posedge ap_clk);
        in_valid <= 1'b0;
    endtask

    // --------------------------------------------------
    // Job sequence shared by the tests
    // --------------------------------------------------
    task automatic run_job(input alu_config_t cfg, input int n, input bit early, input int stall);
        packet_t sent[$];
        int      requests;
        int      dones;
        make_packets(n, sent);
        received.delete();
        requests = request_count;
        dones    = done_count;
        if (stall > 0) begin
            @(posedge ap_clk);
            out_ready <= 1'b0;
        end
        drive_descriptor(n);
        wait_for_count(EV_REQUEST, requests + 1, "no config_request pulse");
        if (aborted) begin
            return;
        end
        // Packets queued during SETUP_WAIT must wait for the configuration
        if (early) begin
            send_packets(sent);
        end
        drive_config(cfg);
        if (!early) begin
            send_packets(sent);
        end
        if (stall > 0) begin
            repeat (stall) @(negedge ap_clk);
            check_bit("out_valid while stalled", 1'b1, out_valid);
            check_packet("head while stalled", expected_packet(cfg, sent[0]), out_packet);
            check_count("done while stalled", 0, done_count - dones);
            @(posedge ap_clk);
            out_ready <= 1'b1;
        end
        wait_for_count(EV_PACKET, n, "results missing at the output");
        wait_for_count(EV_DONE, dones + 1, "no done pulse");
        if (aborted) begin
            return;
        end
        repeat (5) @(negedge ap_clk);
        check_count("result count", n, received.size());
        foreach (sent[i]) begin
            if (i < received.size()) begin
                check_packet($sformatf("packet %0d", i), expected_packet(cfg, sent[i]),
                    received[i]);
            end
        end
        check_count("done pulses", 1, done_count - dones);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset();
        begin_test("reset");
        @(negedge ap_clk);
        check_bit("done", 1'b0, done);
        check_bit("config_request", 1'b0, config_request);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("in_full", 1'b0, in_full);
        run_job(random_config(ALU_PASS), 1, 1'b0, 0);
        end_test();
    endtask

    task automatic test_opcodes();
        begin_test("opcodes");
        for (int op = 0; op < 8; op++) begin
            if (!aborted) begin
                run_job(random_config(alu_opcode_e'(op[2:0])), 4, 1'b0, 0);
            end
        end
        end_test();
    endtask

    task automatic test_order();
        begin_test("order");
        run_job(random_config(ALU_ADD), 6, 1'b1, 0);
        end_test();
    endtask

    task automatic test_backpressure();
        begin_test("backpressure");
        run_job(random_config(ALU_MUL), 12, 1'b0, 20);
        end_test();
    endtask

    task automatic test_completion();
        alu_config_t cfg_a;
        alu_config_t cfg_b;
        begin_test("completion");
        cfg_a = random_config(ALU_XOR);
        cfg_b = random_config(ALU_SUB);
        cfg_b.route_from = ~cfg_a.route_from;
        cfg_b.route_to   = ~cfg_a.route_to;
        run_job(cfg_a, 3, 1'b0, 0);
        if (!aborted) begin
            run_job(cfg_b, 5, 1'b0, 0);
        end
        end_test();
    endtask

    initial begin
        areset_generator = 1'b1;
        descriptor_valid = 1'b0;
        descriptor       = '0;
        config_valid     = 1'b0;
        config_in        = '0;
        in_valid         = 1'b0;
        in_packet        = '0;
        out_ready        = 1'b1;
        repeat (3) @(posedge ap_clk);
        areset_generator <= 1'b0;
        test_reset();
        if (!aborted) begin
            test_opcodes();
        end
        if (!aborted) begin
            test_order();
        end
        if (!aborted) begin
            test_backpressure();
        end
        if (!aborted) begin
            test_completion();
        end
        $display("Counts: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : alu_ops_engine_tb

//--- files.f
+incdir+dv
design/alu_ops_pkg.sv
design/packet_fifo.sv
design/alu_ops_control.sv
design/alu_ops_kernel.sv
design/packet_builder.sv
design/alu_ops_engine.sv
dv/alu_ops_engine_tb.sv

//--- run.sh
#!/bin/sh
# Build the engine testbench with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module alu_ops_engine_tb -Mdir obj_dir > build.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/Valu_ops_engine_tb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
